//--- Bender.yml
package:
  name: hps_io

sources:
  - hps_pkg.sv
  - hps_word_framer.sv
  - hps_user_regs.sv
  - hps_file_loader.sv
  - hps_io_top.sv
  - target: test
    files:
      - tb_hps_checker.sv
      - tb_hps_assert.sv
      - tb_hps_io.sv

//--- all.f
hps_pkg.sv
hps_word_framer.sv
hps_user_regs.sv
hps_file_loader.sv
hps_io_top.sv
tb_hps_checker.sv
tb_hps_assert.sv
tb_hps_io.sv

//--- hps_file_loader.sv
/*
 * Second pipeline stage for file-I/O frames.
 * Keeps the file index and extension, opens and closes a download
 * and turns each data word into one ioctl_wr pulse with its address.
 * With wide set the data is 16 bits and the address steps by 2,
 * otherwise the data is the low byte and the address steps by 1.
 */

`timescale 1ns/1ps
`default_nettype none

module hps_file_loader #(
	parameter int wide = 0
) (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 fio_word_valid,
	input  hps_pkg::hps_word_t   word,
	input  hps_pkg::word_idx_t   idx,
	input  hps_pkg::cmd_t        cmd,
	output logic                 ioctl_download,
	output hps_pkg::hps_word_t   ioctl_index,
	output hps_pkg::file_ext_t   ioctl_file_ext,
	output logic                 ioctl_wr,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output logic [15:0]          ioctl_dout
);

	localparam hps_pkg::ioctl_addr_t step = (wide != 0) ? 27'd2 : 27'd1;

	// address of the next data word
	hps_pkg::ioctl_addr_t next_addr;
	logic [7:0]           start_byte;

	assign start_byte = word[7:0];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			next_addr      <= '0;
		end else begin
			ioctl_wr <= 1'b0;

			if (fio_word_valid && idx != '0) begin
				case (cmd)
					hps_pkg::FIO_FILE_INDEX: ioctl_index <= word;
					hps_pkg::FIO_FILE_INFO: begin
						// high half of the extension comes first
						if (idx == 9'd1)
							ioctl_file_ext[31:16] <= word;
						else if (idx == 9'd2)
							ioctl_file_ext[15:0] <= word;
					end
					hps_pkg::FIO_FILE_TX: begin
						case (idx)
							9'd1: begin
								if (start_byte == 8'h00) begin
									ioctl_download <= 1'b0;
								end else if (start_byte != hps_pkg::TX_UPLOAD_CODE) begin
									ioctl_download <= 1'b1;
									next_addr      <= '0;
								end
							end
							9'd2: next_addr[15:0] <= word;
							9'd3: next_addr[26:16] <= word[10:0];
							default: ;
						endcase
					end
					hps_pkg::FIO_FILE_TX_DAT: begin
						if (ioctl_download) begin
							ioctl_wr   <= 1'b1;
							ioctl_addr <= next_addr;
							ioctl_dout <= (wide != 0) ? word : {8'h00, word[7:0]};
							next_addr  <= next_addr + step;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hps_io_top.sv
/*
 * Top level of the host I/O command block.
 * The framer feeds the user-I/O register stage and the file download
 * stage side by side. Set wide to 1 for 16 bit downloads.
 */

`timescale 1ns/1ps
`default_nettype none

module hps_io_top #(
	parameter int wide = 0
) (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 io_strobe,
	input  logic                 io_enable,
	input  logic                 fp_enable,
	input  hps_pkg::hps_word_t   io_din,
	output hps_pkg::hps_word_t   io_dout,

	// user-I/O side
	input  hps_pkg::status_t     status_in,
	input  logic                 status_set,
	input  hps_pkg::hps_word_t   status_menumask,
	output hps_pkg::cfg_t        cfg,
	output hps_pkg::joy_t        joystick_0,
	output hps_pkg::joy_t        joystick_1,
	output hps_pkg::status_t     status,
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output logic                 direct_video,

	// download side
	output logic                 ioctl_download,
	output hps_pkg::hps_word_t   ioctl_index,
	output hps_pkg::file_ext_t   ioctl_file_ext,
	output logic                 ioctl_wr,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output logic [15:0]          ioctl_dout
);

	logic               uio_word_valid;
	logic               fio_word_valid;
	hps_pkg::hps_word_t word;
	hps_pkg::word_idx_t idx;
	hps_pkg::cmd_t      cmd;
	logic               uio_frame_end;
	logic               fio_active;
	hps_pkg::hps_word_t uio_dout;

	hps_word_framer u_framer (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.io_strobe      (io_strobe),
		.io_enable      (io_enable),
		.fp_enable      (fp_enable),
		.io_din         (io_din),
		.uio_word_valid (uio_word_valid),
		.fio_word_valid (fio_word_valid),
		.word           (word),
		.idx            (idx),
		.cmd            (cmd),
		.uio_frame_end  (uio_frame_end),
		.fio_active     (fio_active)
	);

	hps_user_regs u_user_regs (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.uio_word_valid     (uio_word_valid),
		.word               (word),
		.idx                (idx),
		.cmd                (cmd),
		.uio_frame_end      (uio_frame_end),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.cfg                (cfg),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.uio_dout           (uio_dout)
	);

	hps_file_loader #(
		.wide (wide)
	) u_file_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.fio_word_valid (fio_word_valid),
		.word           (word),
		.idx            (idx),
		.cmd            (cmd),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	// the file channel has no readback in this core, it reads as zero
	// until the registered file frame has closed
	assign io_dout = (io_enable && !fio_active) ? uio_dout : '0;

endmodule

`default_nettype wire

//--- hps_pkg.sv
/*
 * Shared types and constants for the host I/O command block.
 * Holds the bus word types, the user-I/O and file-I/O command codes
 * and the config word field positions. RTL and testbench refer to
 * everything here by scoped name.
 */

`default_nettype none

package hps_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and register types

	typedef logic [15:0] hps_word_t;
	// position of a word in its frame, saturates at all ones
	typedef logic [8:0]  word_idx_t;
	typedef logic [15:0] cmd_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [15:0] cfg_t;
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [31:0] file_ext_t;
	typedef logic [3:0]  stflg_t;

	////////////////////////////////////////////////////////////////////////////
	// command codes

	// user-I/O channel
	localparam cmd_t CMD_CFG        = 16'h0001;
	localparam cmd_t CMD_JOY0       = 16'h0002;
	localparam cmd_t CMD_JOY1       = 16'h0003;
	localparam cmd_t CMD_STATUS     = 16'h001E;
	localparam cmd_t CMD_STATUS_REQ = 16'h0029;
	localparam cmd_t CMD_MENUMASK   = 16'h002E;

	// file-I/O channel
	localparam cmd_t FIO_FILE_TX     = 16'h0053;
	localparam cmd_t FIO_FILE_TX_DAT = 16'h0054;
	localparam cmd_t FIO_FILE_INDEX  = 16'h0055;
	localparam cmd_t FIO_FILE_INFO   = 16'h0056;

	////////////////////////////////////////////////////////////////////////////
	// other constants

	// marker nibble in the status request answer
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;
	// start byte of an upload, not supported here
	localparam logic [7:0] TX_UPLOAD_CODE = 8'hAA;

	// config word fields
	localparam int CFG_BUTTONS_LSB      = 0;
	localparam int CFG_SCANDOUBLER_BIT  = 4;
	localparam int CFG_DIRECT_VIDEO_BIT = 10;

endpackage

`default_nettype wire

//--- hps_user_regs.sv
/*
 * Second pipeline stage for user-I/O frames.
 * Decodes the command of each frame and writes the config, joystick
 * and status registers from the argument words. Also answers the
 * status request and menu mask readback commands on uio_dout, which
 * is cleared at the end of each frame.
 */

`timescale 1ns/1ps
`default_nettype none

module hps_user_regs (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                uio_word_valid,
	input  hps_pkg::hps_word_t  word,
	input  hps_pkg::word_idx_t  idx,
	input  hps_pkg::cmd_t       cmd,
	input  logic                uio_frame_end,
	input  hps_pkg::status_t    status_in,
	input  logic                status_set,
	input  hps_pkg::hps_word_t  status_menumask,
	output hps_pkg::cfg_t       cfg,
	output hps_pkg::joy_t       joystick_0,
	output hps_pkg::joy_t       joystick_1,
	output hps_pkg::status_t    status,
	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	output logic                direct_video,
	output hps_pkg::hps_word_t  uio_dout
);

	logic             status_set_q;
	hps_pkg::stflg_t  stflg;
	hps_pkg::status_t status_req;
	logic [1:0]       quarter;

	// argument words 1 to 4 select a 16 bit quarter, low first
	assign quarter = 2'(idx - 1'b1);

	// config word fields
	assign buttons            = cfg[hps_pkg::CFG_BUTTONS_LSB +: 2];
	assign forced_scandoubler = cfg[hps_pkg::CFG_SCANDOUBLER_BIT];
	assign direct_video       = cfg[hps_pkg::CFG_DIRECT_VIDEO_BIT];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg          <= '0;
			joystick_0   <= '0;
			joystick_1   <= '0;
			status       <= '0;
			status_req   <= '0;
			stflg        <= '0;
			status_set_q <= 1'b0;
			uio_dout     <= '0;
		end else begin
			////////////////////////////////////////////////////////////////////
			// core side status request

			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				stflg      <= stflg + 1'b1;
				status_req <= status_in;
			end

			////////////////////////////////////////////////////////////////////
			// host words

			if (uio_frame_end) begin
				uio_dout <= '0;
			end else if (uio_word_valid) begin
				// readback holds only until the next word
				uio_dout <= '0;
				if (idx == '0) begin
					if (word == hps_pkg::CMD_STATUS_REQ)
						uio_dout <= {8'h00, hps_pkg::STATUS_REQ_TAG, stflg};
				end else begin
					case (cmd)
						hps_pkg::CMD_CFG: cfg <= word;
						hps_pkg::CMD_JOY0: begin
							if (idx == 9'd1)
								joystick_0[15:0] <= word;
							else if (idx == 9'd2)
								joystick_0[31:16] <= word;
						end
						hps_pkg::CMD_JOY1: begin
							if (idx == 9'd1)
								joystick_1[15:0] <= word;
							else if (idx == 9'd2)
								joystick_1[31:16] <= word;
						end
						hps_pkg::CMD_STATUS: begin
							if (idx <= 9'd4)
								status[{quarter, 4'b0000} +: 16] <= word;
						end
						hps_pkg::CMD_STATUS_REQ: begin
							if (idx <= 9'd4)
								uio_dout <= status_req[{quarter, 4'b0000} +: 16];
						end
						hps_pkg::CMD_MENUMASK: begin
							if (idx == 9'd1)
								uio_dout <= status_menumask;
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hps_word_framer.sv
/*
 * First pipeline stage of the host I/O block.
 * Registers every strobed host word, numbers it within its frame and
 * hands it to the user-I/O or file-I/O stage as a one-cycle pulse.
 * The first word of a frame is kept as the frame's command.
 */

`timescale 1ns/1ps
`default_nettype none

module hps_word_framer (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               io_strobe,
	input  logic               io_enable,
	input  logic               fp_enable,
	input  hps_pkg::hps_word_t io_din,
	output logic               uio_word_valid,
	output logic               fio_word_valid,
	output hps_pkg::hps_word_t word,
	output hps_pkg::word_idx_t idx,
	output hps_pkg::cmd_t      cmd,
	output logic               uio_frame_end,
	output logic               fio_active
);

	logic               io_enable_q;
	logic               fp_enable_q;
	logic               frame_start;
	hps_pkg::word_idx_t word_cnt;
	hps_pkg::word_idx_t word_pos;

	// a word arriving with the enable edge is the command word
	assign frame_start = (io_enable & ~io_enable_q) | (fp_enable & ~fp_enable_q);
	assign word_pos    = frame_start ? '0 : word_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			io_enable_q    <= 1'b0;
			fp_enable_q    <= 1'b0;
			fio_active     <= 1'b0;
			uio_frame_end  <= 1'b0;
			uio_word_valid <= 1'b0;
			fio_word_valid <= 1'b0;
			word_cnt       <= '0;
			word           <= '0;
			idx            <= '0;
			cmd            <= '0;
		end else begin
			io_enable_q   <= io_enable;
			fp_enable_q   <= fp_enable;
			fio_active    <= fp_enable;
			uio_frame_end <= io_enable_q & ~io_enable;

			// route by the enable that is high, only one can be
			uio_word_valid <= io_strobe & io_enable;
			fio_word_valid <= io_strobe & fp_enable;

			if (!io_enable && !fp_enable) begin
				word_cnt <= '0;
			end else if (io_strobe) begin
				word <= io_din;
				idx  <= word_pos;
				if (word_pos == '0)
					cmd <= io_din;
				// saturate so long frames keep a stable index
				if (word_pos != '1)
					word_cnt <= word_pos + 1'b1;
			end else if (frame_start) begin
				word_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_hps_assert.sv
/*
 * Concurrent assertions on the framer outputs and the download writes.
 * Bound into the top level so the internal word_valid pulses are visible.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_hps_assert #(
	parameter int wide = 0
) (
	input logic                 clk_sys,
	input logic                 rst,
	input logic                 uio_word_valid,
	input logic                 fio_word_valid,
	input logic                 ioctl_wr,
	input logic                 ioctl_download,
	input hps_pkg::ioctl_addr_t ioctl_addr
);

	localparam hps_pkg::ioctl_addr_t step = (wide != 0) ? 27'd2 : 27'd1;

	hps_pkg::ioctl_addr_t last_addr;
	logic                 have_last;

	// address of the previous write in the current download
	always_ff @(posedge clk_sys) begin
		if (rst || !ioctl_download) begin
			have_last <= 1'b0;
		end else if (ioctl_wr) begin
			last_addr <= ioctl_addr;
			have_last <= 1'b1;
		end
	end

	assert property (@(posedge clk_sys) disable iff (rst)
		!(uio_word_valid && fio_word_valid))
		else $error("user and file word_valid high in the same cycle");

	assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr high outside a download");

	assert property (@(posedge clk_sys) disable iff (rst)
		(ioctl_wr && have_last) |-> (ioctl_addr == last_addr + step))
		else $error("write address did not advance by the step");

endmodule

bind hps_io_top tb_hps_assert #(
	.wide (wide)
) u_assert (
	.clk_sys        (clk_sys),
	.rst            (rst),
	.uio_word_valid (uio_word_valid),
	.fio_word_valid (fio_word_valid),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download),
	.ioctl_addr     (ioctl_addr)
);

`default_nettype wire

//--- tb_hps_checker.sv
/*
 * Checking side of the host I/O testbench.
 * Compares the DUT registers when the testbench asks for it, and on its
 * own compares every readback word and every ioctl_wr pulse against the
 * queues of expected values. Keeps the per-test and total error counts.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_hps_checker (
	input logic                 clk_sys,
	input logic                 io_strobe,
	input logic                 io_enable,
	input hps_pkg::hps_word_t   io_dout,
	input hps_pkg::cfg_t        cfg,
	input logic [1:0]           buttons,
	input logic                 forced_scandoubler,
	input logic                 direct_video,
	input hps_pkg::joy_t        joystick_0,
	input hps_pkg::joy_t        joystick_1,
	input hps_pkg::status_t     status,
	input logic                 ioctl_download,
	input hps_pkg::hps_word_t   ioctl_index,
	input hps_pkg::file_ext_t   ioctl_file_ext,
	input logic                 ioctl_wr,
	input hps_pkg::ioctl_addr_t ioctl_addr,
	input logic [15:0]          ioctl_dout
);

	int                   error_count = 0;
	int                   test_count  = 0;
	int                   test_errors = 0;
	string                test_name;
	hps_pkg::hps_word_t   rb_q [$];
	hps_pkg::ioctl_addr_t wr_addr_q [$];
	logic [15:0]          wr_data_q [$];
	// strobes of a readback frame, two negedges deep
	logic [1:0]           rb_pipe = 2'b00;

	task automatic compare(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic expect_readback(input hps_pkg::hps_word_t value);
		rb_q.push_back(value);
	endtask

	task automatic expect_write(input hps_pkg::ioctl_addr_t addr, input logic [15:0] data);
		wr_addr_q.push_back(addr);
		wr_data_q.push_back(data);
	endtask

	task automatic check_user(input hps_pkg::cfg_t exp_cfg, input logic [3:0] exp_fields,
			input hps_pkg::joy_t exp_j0, input hps_pkg::joy_t exp_j1,
			input hps_pkg::status_t exp_status);
		compare("cfg", cfg, exp_cfg);
		compare("cfg fields", {direct_video, forced_scandoubler, buttons}, exp_fields);
		compare("joystick_0", joystick_0, exp_j0);
		compare("joystick_1", joystick_1, exp_j1);
		compare("status", status, exp_status);
	endtask

	task automatic check_file(input hps_pkg::hps_word_t exp_index,
			input hps_pkg::file_ext_t exp_ext, input logic exp_download);
		compare("ioctl_index", ioctl_index, exp_index);
		compare("ioctl_file_ext", ioctl_file_ext, exp_ext);
		compare("ioctl_download", ioctl_download, exp_download);
	endtask

	task automatic end_test();
		if (wr_addr_q.size() != 0) begin
			$display("At %0t ns, %0d expected ioctl writes never happened",
				$time, wr_addr_q.size());
			error_count++;
			test_errors++;
			wr_addr_q.delete();
			wr_data_q.delete();
		end
		if (rb_q.size() != 0) begin
			$display("At %0t ns, %0d expected readback words were never sampled",
				$time, rb_q.size());
			error_count++;
			test_errors++;
			rb_q.delete();
		end
		test_count++;
		if (test_errors == 0)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, test_errors);
	endtask

	task automatic report_counts();
		$display("%0d tests run, %0d errors", test_count, error_count);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// readback and write monitor, sampled away from the rising edge

	always @(negedge clk_sys) begin
		// io_dout is valid two cycles after its strobe
		if (rb_pipe[1])
			compare("io_dout", io_dout, rb_q.pop_front());
		rb_pipe = {rb_pipe[0], io_strobe && io_enable && (rb_q.size() > 0)};

		if (ioctl_wr) begin
			if (wr_addr_q.size() == 0) begin
				$display("At %0t ns, an ioctl_wr pulse came with no write expected", $time);
				error_count++;
				test_errors++;
			end else begin
				compare("ioctl_addr", ioctl_addr, wr_addr_q.pop_front());
				compare("ioctl_dout", ioctl_dout, wr_data_q.pop_front());
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_hps_io.sv
/*
 * Testbench top for the host I/O command block.
 * Sends user-I/O and file-I/O frames with random gaps between the words,
 * works out the expected register values from the words it sent and hands
 * them to the checker. A watchdog ends a run that stops making progress.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_hps_io;

	localparam int MAX_GAP     = 3;
	localparam int K_MAX       = 24;
	localparam int MAX_PULSES  = 20;
	localparam int FRAMES      = 11;
	// every word of every frame, the data frame at its longest
	localparam int TOTAL_WORDS = 31 + K_MAX + 1;
	localparam int WATCHDOG_CYCLES =
		TOTAL_WORDS * (MAX_GAP + 1) + FRAMES * 6 + MAX_PULSES * 2 + 100;

	logic                 clk_sys;
	logic                 rst;
	logic                 io_strobe;
	logic                 io_enable;
	logic                 fp_enable;
	hps_pkg::hps_word_t   io_din;
	hps_pkg::hps_word_t   io_dout;
	hps_pkg::status_t     status_in;
	logic                 status_set;
	hps_pkg::hps_word_t   status_menumask;
	hps_pkg::cfg_t        cfg;
	hps_pkg::joy_t        joystick_0;
	hps_pkg::joy_t        joystick_1;
	hps_pkg::status_t     status;
	logic [1:0]           buttons;
	logic                 forced_scandoubler;
	logic                 direct_video;
	logic                 ioctl_download;
	hps_pkg::hps_word_t   ioctl_index;
	hps_pkg::file_ext_t   ioctl_file_ext;
	logic                 ioctl_wr;
	hps_pkg::ioctl_addr_t ioctl_addr;
	logic [15:0]          ioctl_dout;

	// argument words of the frame being sent
	hps_pkg::hps_word_t   args [0:31];

	// expected register state
	hps_pkg::cfg_t        exp_cfg;
	hps_pkg::joy_t        exp_j0;
	hps_pkg::joy_t        exp_j1;
	hps_pkg::status_t     exp_status;
	hps_pkg::hps_word_t   exp_index;
	hps_pkg::file_ext_t   exp_ext;
	hps_pkg::status_t     last_status_in;
	hps_pkg::ioctl_addr_t start_addr;
	int                   n_pulses;
	int                   k;

	hps_io_top #(
		.wide (1)
	) UUT (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.cfg                (cfg),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	tb_hps_checker chk (
		.clk_sys            (clk_sys),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.io_dout            (io_dout),
		.cfg                (cfg),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model

	// {direct_video, forced_scandoubler, buttons}
	function automatic logic [3:0] cfg_fields(input hps_pkg::cfg_t c);
		return {c[10], c[4], c[1:0]};
	endfunction

	function automatic hps_pkg::joy_t joy_value(input hps_pkg::hps_word_t lo,
			input hps_pkg::hps_word_t hi);
		return {hi, lo};
	endfunction

	function automatic hps_pkg::status_t status_value(input hps_pkg::hps_word_t q0,
			input hps_pkg::hps_word_t q1, input hps_pkg::hps_word_t q2,
			input hps_pkg::hps_word_t q3);
		return {q3, q2, q1, q0};
	endfunction

	// tag nibble above the request count, which wraps at 16
	function automatic hps_pkg::hps_word_t req_header(input int pulses);
		return {8'h00, hps_pkg::STATUS_REQ_TAG, 4'(pulses % 16)};
	endfunction

	function automatic hps_pkg::ioctl_addr_t write_addr(input hps_pkg::ioctl_addr_t first,
			input int n);
		return 27'(first + 27'(2 * n));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic fill_args(input int n);
		for (int i = 0; i < n; i++)
			args[i] = hps_pkg::hps_word_t'($urandom);
	endtask

	// command word, then args[0..n-1], each strobed after a random gap
	task automatic send_frame(input logic file_ch, input hps_pkg::cmd_t cmd, input int n);
		int gap;
		if (file_ch)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		for (int i = 0; i <= n; i++) begin
			if (i == 0)
				io_din = cmd;
			else
				io_din = args[i - 1];
			io_strobe = 1'b1;
			next_cycle();
			io_strobe = 1'b0;
			gap = $urandom_range(MAX_GAP, 0);
			repeat (gap) next_cycle();
		end
		// last word still in the pipeline
		repeat (3) next_cycle();
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (3) next_cycle();
	endtask

	task automatic check_user_state();
		chk.check_user(exp_cfg, cfg_fields(exp_cfg), exp_j0, exp_j1, exp_status);
	endtask

	task automatic check_file_state(input logic exp_download);
		chk.check_file(exp_index, exp_ext, exp_download);
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'hefd3_488b));
		rst             = 1'b1;
		io_strobe       = 1'b0;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_din          = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		exp_cfg         = '0;
		exp_j0          = '0;
		exp_j1          = '0;
		exp_status      = '0;
		exp_index       = '0;
		exp_ext         = '0;
		repeat (5) @(posedge clk_sys);
		#1;
		rst = 1'b0;
		next_cycle();

		chk.begin_test("config word");
		fill_args(1);
		send_frame(1'b0, hps_pkg::CMD_CFG, 1);
		exp_cfg = args[0];
		check_user_state();
		chk.end_test();

		chk.begin_test("joysticks");
		fill_args(2);
		send_frame(1'b0, hps_pkg::CMD_JOY0, 2);
		exp_j0 = joy_value(args[0], args[1]);
		fill_args(2);
		send_frame(1'b0, hps_pkg::CMD_JOY1, 2);
		exp_j1 = joy_value(args[0], args[1]);
		check_user_state();
		chk.end_test();

		chk.begin_test("status word");
		fill_args(4);
		send_frame(1'b0, hps_pkg::CMD_STATUS, 4);
		exp_status = status_value(args[0], args[1], args[2], args[3]);
		check_user_state();
		chk.end_test();

		chk.begin_test("status request");
		n_pulses = $urandom_range(MAX_PULSES, 1);
		for (int i = 0; i < n_pulses; i++) begin
			last_status_in = {$urandom, $urandom};
			status_in      = last_status_in;
			status_set     = 1'b1;
			next_cycle();
			status_set = 1'b0;
			next_cycle();
		end
		chk.expect_readback(req_header(n_pulses));
		for (int q = 0; q < 4; q++)
			chk.expect_readback(last_status_in[16 * q +: 16]);
		fill_args(4);
		send_frame(1'b0, hps_pkg::CMD_STATUS_REQ, 4);
		chk.end_test();

		chk.begin_test("menu mask");
		status_menumask = hps_pkg::hps_word_t'($urandom);
		chk.expect_readback('0);
		chk.expect_readback(status_menumask);
		fill_args(1);
		send_frame(1'b0, hps_pkg::CMD_MENUMASK, 1);
		chk.end_test();

		chk.begin_test("file index and extension");
		fill_args(1);
		send_frame(1'b1, hps_pkg::FIO_FILE_INDEX, 1);
		exp_index = args[0];
		fill_args(2);
		send_frame(1'b1, hps_pkg::FIO_FILE_INFO, 2);
		exp_ext = {args[0], args[1]};
		check_file_state(1'b0);
		chk.end_test();

		chk.begin_test("download");
		start_addr = 27'($urandom);
		args[0]    = 16'h0001;
		args[1]    = start_addr[15:0];
		args[2]    = {5'b00000, start_addr[26:16]};
		send_frame(1'b1, hps_pkg::FIO_FILE_TX, 3);
		check_file_state(1'b1);
		k = $urandom_range(K_MAX, 1);
		fill_args(k);
		for (int i = 0; i < k; i++)
			chk.expect_write(write_addr(start_addr, i), args[i]);
		send_frame(1'b1, hps_pkg::FIO_FILE_TX_DAT, k);
		check_file_state(1'b1);
		args[0] = 16'h0000;
		send_frame(1'b1, hps_pkg::FIO_FILE_TX, 1);
		check_file_state(1'b0);
		chk.end_test();

		chk.report_counts();
		if (chk.error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
